// ==== common/icachePkg.sv ====
// fixed RISC-V widths, port structs and controller states shared by the instruction cache
package icachePkg;

    // byte address and instruction word widths of the core
    localparam int addrWidth = 32;
    localparam int wordWidth = 32;

    // fetch request from the core, held until a response is seen
    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] addr;
    } fetchReq_t;

    // fetch response back to the core
    typedef struct packed {
        logic                 valid;
        logic [wordWidth-1:0] data;
    } fetchRsp_t;

    // refill request towards the backing memory
    // addr is always block aligned
    typedef struct packed {
        logic                 req;
        logic [addrWidth-1:0] addr;
    } memReq_t;

    // one refill beat from the backing memory
    typedef struct packed {
        logic                 valid;
        logic [wordWidth-1:0] data;
    } memRsp_t;

    // miss controller states
    typedef enum logic [1:0] {
        sLookup,
        sRequest,
        sCollect,
        sFill
    } ctrlState_t;

endpackage

// ==== icache/icacheArray.sv ====
// tag, data and replacement state of the cache, giving a combinational hit and filling on request
module icacheArray #(
    parameter int numWays    = 4,
    parameter int numSets    = 8,
    parameter int blockWords = 4
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               lookupEn,
    input  logic                                               fillEn,
    input  logic [icachePkg::addrWidth-3-$clog2(blockWords):0] blockAddr,
    input  logic [blockWords*icachePkg::wordWidth-1:0]         fillBlock,
    output logic                                               hit,
    output logic [blockWords*icachePkg::wordWidth-1:0]         hitBlock
);
    import icachePkg::*;

    localparam int offsetWidth    = $clog2(blockWords);
    localparam int indexWidth     = $clog2(numSets);
    localparam int blockAddrWidth = addrWidth - 2 - offsetWidth;
    localparam int tagWidth       = blockAddrWidth - indexWidth;
    localparam int blockWidth     = blockWords * wordWidth;

    // per-set valid and MRU status bits, one per way
    logic [numWays-1:0]    validBits  [numSets];
    logic [numWays-1:0]    statusBits [numSets];

    // tag and data storage
    logic [tagWidth-1:0]   tagMem     [numSets][numWays];
    logic [blockWidth-1:0] dataMem    [numSets][numWays];

    logic [indexWidth-1:0] index;
    logic [tagWidth-1:0]   tag;
    logic [numWays-1:0]    hitWay;
    logic [numWays-1:0]    victimWay;
    logic [numWays-1:0]    touchMask;
    logic [numWays-1:0]    nextStatus;

    // blockAddr is {tag, index}
    assign index = blockAddr[indexWidth-1:0];
    assign tag   = blockAddr[blockAddrWidth-1:indexWidth];

    // compare the tag against every way of the set
    always_comb begin
        hitBlock = '0;
        for (int w = 0; w < numWays; w++) begin
            hitWay[w] = lookupEn && validBits[index][w] && (tagMem[index][w] == tag);
            if (hitWay[w]) begin
                hitBlock = hitBlock | dataMem[index][w];
            end
        end
    end

    assign hit = |hitWay;

    // victim choice
    // first invalid way wins, otherwise the first way with a clear status bit
    always_comb begin
        logic found;
        found     = 1'b0;
        victimWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (!found && !validBits[index][w]) begin
                victimWay[w] = 1'b1;
                found        = 1'b1;
            end
        end
        for (int w = 0; w < numWays; w++) begin
            if (!found && !statusBits[index][w]) begin
                victimWay[w] = 1'b1;
                found        = 1'b1;
            end
        end
        // a full status vector only survives with a single way
        if (!found) begin
            victimWay[0] = 1'b1;
        end
    end

    // way touched this cycle, by a fill or by a lookup hit
    always_comb begin
        touchMask  = fillEn ? victimWay : hitWay;
        nextStatus = statusBits[index] | touchMask;
        // all ones would carry no history, keep only the touched way
        if (&nextStatus) begin
            nextStatus = touchMask;
        end
    end

    // valid and status state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < numSets; s++) begin
                validBits[s]  <= '0;
                statusBits[s] <= '0;
            end
        end else begin
            if (|touchMask) begin
                statusBits[index] <= nextStatus;
            end
            if (fillEn) begin
                validBits[index] <= validBits[index] | victimWay;
            end
        end
    end

    // tag and data written into the victim way
    always_ff @(posedge clk) begin
        if (fillEn) begin
            for (int w = 0; w < numWays; w++) begin
                if (victimWay[w]) begin
                    tagMem[index][w]  <= tag;
                    dataMem[index][w] <= fillBlock;
                end
            end
        end
    end

endmodule

// ==== icache/icacheController.sv ====
// miss FSM of the cache, collects refill beats and returns the fetched word to the core
module icacheController #(
    parameter int numWays    = 4,
    parameter int numSets    = 8,
    parameter int blockWords = 4
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  icachePkg::fetchReq_t                               fetchReq,
    output icachePkg::fetchRsp_t                               fetchRsp,
    output icachePkg::memReq_t                                 memReq,
    input  icachePkg::memRsp_t                                 memRsp,
    input  logic                                               hit,
    input  logic [blockWords*icachePkg::wordWidth-1:0]         hitBlock,
    output logic                                               lookupEn,
    output logic                                               fillEn,
    output logic [icachePkg::addrWidth-3-$clog2(blockWords):0] blockAddr,
    output logic [blockWords*icachePkg::wordWidth-1:0]         fillBlock
);
    import icachePkg::*;

    localparam int offsetWidth    = $clog2(blockWords);
    localparam int blockAddrWidth = addrWidth - 2 - offsetWidth;
    localparam int blockWidth     = blockWords * wordWidth;

    // geometry must be powers of two with at least two words per block
    if (numWays < 1 || numSets < 2 || (numSets & (numSets - 1)) != 0 ||
        blockWords < 2 || (blockWords & (blockWords - 1)) != 0) begin : geomCheck
        $error("unsupported cache geometry");
    end

    ctrlState_t                state;
    ctrlState_t                nextState;
    logic [offsetWidth-1:0]    beatCnt;
    logic [blockWidth-1:0]     fillBuf;
    logic [blockAddrWidth-1:0] missBlock;
    logic [blockAddrWidth-1:0] fetchBlock;
    logic [offsetWidth-1:0]    wordOff;
    logic                      lastBeat;

    // fetch address split
    assign fetchBlock = fetchReq.addr[addrWidth-1 -: blockAddrWidth];
    assign wordOff    = fetchReq.addr[2 +: offsetWidth];

    assign lastBeat = memRsp.valid && (beatCnt == offsetWidth'(blockWords - 1));

    // array control
    assign lookupEn  = (state == sLookup) && fetchReq.valid;
    assign fillEn    = (state == sFill);
    assign blockAddr = (state == sLookup) ? fetchBlock : missBlock;
    assign fillBlock = fillBuf;

    // hit data goes straight back to the core
    always_comb begin
        fetchRsp.valid = lookupEn && hit;
        fetchRsp.data  = hitBlock[wordOff*wordWidth +: wordWidth];
    end

    // one-cycle refill strobe with the block-aligned address
    always_comb begin
        memReq.req  = (state == sRequest);
        memReq.addr = {missBlock, {(offsetWidth + 2){1'b0}}};
    end

    always_comb begin
        nextState = state;
        case (state)
            sLookup: begin
                if (fetchReq.valid && !hit) begin
                    nextState = sRequest;
                end
            end
            sRequest: nextState = sCollect;
            sCollect: begin
                // slow memory only holds us here longer
                if (lastBeat) begin
                    nextState = sFill;
                end
            end
            sFill: nextState = sLookup;
            default: nextState = sLookup;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= sLookup;
            beatCnt <= '0;
        end else begin
            state <= nextState;
            if (state == sRequest) begin
                beatCnt <= '0;
            end else if (state == sCollect && memRsp.valid) begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

    // block address of the missing fetch, kept for the fill
    always_ff @(posedge clk) begin
        if (state == sLookup && fetchReq.valid && !hit) begin
            missBlock <= fetchBlock;
        end
    end

    // beats come in address order
    // after the last one the first beat sits in slot 0
    always_ff @(posedge clk) begin
        if (state == sCollect && memRsp.valid) begin
            fillBuf <= {memRsp.data, fillBuf[blockWidth-1:wordWidth]};
        end
    end

endmodule

// ==== source/icacheTop.sv ====
// instruction cache top level, joins the miss controller to the tag and data arrays
module icacheTop #(
    parameter int numWays    = 4,
    parameter int numSets    = 8,
    parameter int blockWords = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  icachePkg::fetchReq_t fetchReq,
    output icachePkg::fetchRsp_t fetchRsp,
    output icachePkg::memReq_t   memReq,
    input  icachePkg::memRsp_t   memRsp
);
    import icachePkg::*;

    localparam int blockAddrWidth = addrWidth - 2 - $clog2(blockWords);
    localparam int blockWidth     = blockWords * wordWidth;

    // controller to array
    logic                      lookupEn;
    logic                      fillEn;
    logic [blockAddrWidth-1:0] blockAddr;
    logic [blockWidth-1:0]     fillBlock;

    // array to controller
    logic                      hit;
    logic [blockWidth-1:0]     hitBlock;

    icacheController #(
        .numWays    (numWays),
        .numSets    (numSets),
        .blockWords (blockWords)
    ) icacheController_inst (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchRsp  (fetchRsp),
        .memReq    (memReq),
        .memRsp    (memRsp),
        .hit       (hit),
        .hitBlock  (hitBlock),
        .lookupEn  (lookupEn),
        .fillEn    (fillEn),
        .blockAddr (blockAddr),
        .fillBlock (fillBlock)
    );

    icacheArray #(
        .numWays    (numWays),
        .numSets    (numSets),
        .blockWords (blockWords)
    ) icacheArray_inst (
        .clk       (clk),
        .rst       (rst),
        .lookupEn  (lookupEn),
        .fillEn    (fillEn),
        .blockAddr (blockAddr),
        .fillBlock (fillBlock),
        .hit       (hit),
        .hitBlock  (hitBlock)
    );

endmodule

// ==== bench/tbClock.sv ====
// free-running testbench clock, instantiated once by the testbench top
module tbClock #(
    parameter int periodNs = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

endmodule

// ==== bench/icache_props.sv ====
// concurrent protocol assertions, bound into every instance of the cache miss controller
module icacheProps (
    input logic                   clk,
    input logic                   rst,
    input icachePkg::fetchReq_t   fetchReq,
    input icachePkg::fetchRsp_t   fetchRsp,
    input icachePkg::memReq_t     memReq,
    input icachePkg::ctrlState_t  state
);
    timeunit 1ns;
    timeprecision 1ps;
    import icachePkg::*;

    // failure count for the end-of-run summary
    int assertFails = 0;

    // refill strobe lasts exactly one cycle
    reqOnePulse: assert property (@(posedge clk) disable iff (!rst)
        memReq.req |=> !memReq.req)
        else begin
            $error("refill request strobe held longer than one cycle");
            assertFails++;
        end

    // no answer to the core unless it is asking
    rspNeedsReq: assert property (@(posedge clk) disable iff (!rst)
        fetchRsp.valid |-> fetchReq.valid)
        else begin
            $error("response valid raised without fetch valid");
            assertFails++;
        end

    reqOnlyInRequest: assert property (@(posedge clk) disable iff (!rst)
        memReq.req |-> (state == sRequest))
        else begin
            $error("refill request outside the request state");
            assertFails++;
        end

    // the held fetch hits in the lookup right after a fill
    fillThenHit: assert property (@(posedge clk) disable iff (!rst)
        (state == sFill) |=> fetchRsp.valid)
        else begin
            $error("lookup after a fill did not hit");
            assertFails++;
        end

endmodule

// ==== bench/icacheChecker.sv ====
// watches the cache ports, checks fetched words and refill counts, prints one line per fetch
module icacheChecker #(
    parameter int                             blockWords = 4,
    parameter logic [icachePkg::addrWidth-1:0] memPattern = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  icachePkg::fetchReq_t fetchReq,
    input  icachePkg::fetchRsp_t fetchRsp,
    input  icachePkg::memReq_t   memReq,
    input  int                   testNum,
    input  logic                 expMiss,
    output int                   passCount,
    output int                   failCount
);
    timeunit 1ns;
    timeprecision 1ps;
    import icachePkg::*;

    // clears byte and word offset bits
    localparam logic [addrWidth-1:0] blockMask = ~addrWidth'(blockWords * 4 - 1);

    int   refillCnt;
    logic rowBad;

    initial begin
        passCount = 0;
        failCount = 0;
        refillCnt = 0;
        rowBad    = 1'b0;
    end

    always @(posedge clk) begin : compareOnEdge
        logic [wordWidth-1:0] expWord;
        int                   expRefills;
        if (rst) begin
            if (memReq.req) begin
                refillCnt = refillCnt + 1;
                if (memReq.addr !== (fetchReq.addr & blockMask)) begin
                    $display("ERROR memReq.addr expected %h got %h",
                             fetchReq.addr & blockMask, memReq.addr);
                    rowBad = 1'b1;
                end
            end
            if (fetchRsp.valid) begin
                // backing memory holds address xor pattern
                expWord    = fetchReq.addr ^ memPattern;
                expRefills = expMiss ? 1 : 0;
                if (fetchRsp.data !== expWord) begin
                    $display("ERROR fetchRsp.data expected %h got %h", expWord, fetchRsp.data);
                    rowBad = 1'b1;
                end
                if (refillCnt != expRefills) begin
                    $display("ERROR refill count expected %h got %h", expRefills, refillCnt);
                    rowBad = 1'b1;
                end
                $display("test %0d fetch %h %s %s", testNum, fetchReq.addr,
                         expMiss ? "miss" : "hit ", rowBad ? "FAILED" : "ok");
                if (rowBad) begin
                    failCount = failCount + 1;
                end else begin
                    passCount = passCount + 1;
                end
                refillCnt = 0;
                rowBad    = 1'b0;
            end
        end
    end

endmodule

// ==== bench/icacheTb.sv ====
// testbench top, runs the fetch table against the cache with a random-latency backing memory
module icacheTb;
    timeunit 1ns;
    timeprecision 1ps;
    import icachePkg::*;

    localparam int                   numWays       = 4;
    localparam int                   numSets       = 8;
    localparam int                   blockWords    = 4;
    localparam int                   timeoutCycles = 200;
    localparam logic [addrWidth-1:0] memPattern    = 32'h5A3C_96E1;

    typedef struct packed {
        logic [7:0]           testNum;
        logic [addrWidth-1:0] addr;
        logic                 expMiss;
    } stimRow_t;

    logic      clk;
    logic      rst;
    fetchReq_t fetchReq;
    fetchRsp_t fetchRsp;
    memReq_t   memReq;
    memRsp_t   memRsp;
    int        testNum;
    logic      expMiss;
    int        passCount;
    int        failCount;
    int        timeoutCount;
    integer    seed;
    stimRow_t  stimTable[$];

    tbClock #(.periodNs(40)) tbClock_inst (.clk(clk));

    icacheTop #(
        .numWays    (numWays),
        .numSets    (numSets),
        .blockWords (blockWords)
    ) icacheTop_inst (
        .clk      (clk),
        .rst      (rst),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .memReq   (memReq),
        .memRsp   (memRsp)
    );

    icacheChecker #(
        .blockWords (blockWords),
        .memPattern (memPattern)
    ) icacheChecker_inst (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchRsp  (fetchRsp),
        .memReq    (memReq),
        .testNum   (testNum),
        .expMiss   (expMiss),
        .passCount (passCount),
        .failCount (failCount)
    );

    bind icacheController icacheProps icacheProps_inst (
        .clk      (clk),
        .rst      (rst),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .memReq   (memReq),
        .state    (state)
    );

    function automatic logic [wordWidth-1:0] memWord(input logic [addrWidth-1:0] addr);
        return addr ^ memPattern;
    endfunction

    task automatic addRow(input int t, input logic [addrWidth-1:0] addr, input logic miss);
        stimRow_t row;
        row.testNum = 8'(t);
        row.addr    = addr;
        row.expMiss = miss;
        stimTable.push_back(row);
    endtask

    // set 3 holds tags A 0x2030, B 0x20B0, C 0x2130, D 0x21B0
    // hits B C A D leave status 1001 so E evicts B, and B then evicts C
    task automatic buildTable();
        addRow(1, 32'h0000_1000, 1'b1);
        addRow(1, 32'h0000_1000, 1'b0);
        addRow(2, 32'h0000_1004, 1'b0);
        addRow(2, 32'h0000_1008, 1'b0);
        addRow(2, 32'h0000_100C, 1'b0);
        addRow(3, 32'h0000_2030, 1'b1);
        addRow(3, 32'h0000_20B0, 1'b1);
        addRow(3, 32'h0000_2130, 1'b1);
        addRow(3, 32'h0000_21B0, 1'b1);
        addRow(3, 32'h0000_20B4, 1'b0);
        addRow(3, 32'h0000_2138, 1'b0);
        addRow(3, 32'h0000_203C, 1'b0);
        addRow(3, 32'h0000_21B8, 1'b0);
        addRow(4, 32'h0000_2230, 1'b1);
        addRow(4, 32'h0000_20B0, 1'b1);
        addRow(4, 32'h0000_2034, 1'b0);
        addRow(4, 32'h0000_21BC, 1'b0);
        addRow(4, 32'h0000_2238, 1'b0);
        addRow(5, 32'h0000_1000, 1'b1);
        addRow(5, 32'h0000_100C, 1'b0);
        addRow(6, 32'h0000_3040, 1'b1);
        addRow(6, 32'h0000_3044, 1'b0);
        addRow(6, 32'h0000_3048, 1'b0);
        addRow(6, 32'h0000_304C, 1'b0);
        addRow(6, 32'h0000_1008, 1'b0);
        addRow(6, 32'h0000_40C0, 1'b1);
        addRow(6, 32'h0000_40C4, 1'b0);
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic waitResponse(output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
            seen = fetchRsp.valid;
        end
    endtask

    // backing memory, beats in address order with 1 to 4 idle cycles before each
    initial begin : memoryModel
        logic [addrWidth-1:0] baseAddr;
        int                   gap;
        memRsp <= '0;
        forever begin
            @(posedge clk);
            if (rst && memReq.req) begin
                baseAddr = memReq.addr;
                for (int b = 0; b < blockWords; b++) begin
                    gap = 1 + int'($unsigned($random(seed)) % 4);
                    repeat (gap) @(posedge clk);
                    memRsp <= {1'b1, memWord(baseAddr + addrWidth'(4 * b))};
                    @(posedge clk);
                    memRsp <= '0;
                end
            end
        end
    end

    initial begin : mainSequence
        stimRow_t row;
        int       prevTest;
        logic     gotRsp;
        int       propFails;
        seed         = 95417;
        timeoutCount = 0;
        prevTest     = 0;
        rst      <= 1'b0;
        fetchReq <= '0;
        testNum  <= 0;
        expMiss  <= 1'b0;
        buildTable();
        applyReset();
        foreach (stimTable[i]) begin
            row = stimTable[i];
            // second reset drops everything cached so far
            if (row.testNum == 5 && prevTest != 5) begin
                applyReset();
            end
            prevTest = row.testNum;
            @(posedge clk);
            fetchReq <= {1'b1, row.addr};
            testNum  <= row.testNum;
            expMiss  <= row.expMiss;
            waitResponse(gotRsp);
            fetchReq <= '0;
            if (!gotRsp) begin
                $display("test %0d fetch %h got no response within %0d cycles",
                         row.testNum, row.addr, timeoutCycles);
                timeoutCount++;
                break;
            end
        end
        repeat (2) @(posedge clk);
        propFails = icacheTop_inst.icacheController_inst.icacheProps_inst.assertFails;
        $display("fetches %0d, passed %0d, failed %0d, timed out %0d, assertion failures %0d",
                 stimTable.size(), passCount, failCount, timeoutCount, propFails);
        if (failCount == 0 && timeoutCount == 0 && propFails == 0 &&
            passCount == stimTable.size()) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== icacheTop.f ====
common/icachePkg.sv
icache/icacheArray.sv
icache/icacheController.sv
source/icacheTop.sv
bench/tbClock.sv
bench/icache_props.sv
bench/icacheChecker.sv
bench/icacheTb.sv
